//--- prefetch_cfg.svh
// Widths and depth are shared by RTL and testbench; queue depth must be a power of two
`ifndef PREFETCH_CFG_SVH
`define PREFETCH_CFG_SVH

// Bus widths, one word each
`define PF_ADDR_W 32
`define PF_DATA_W 32

// Prefetch queue entries
`define PF_QUEUE_DEPTH 8

// Occupancy and window values, depth plus one
`define PF_CNT_W 4

// Watchdog prescaler width
`define PF_WD_W 10

`endif

//--- prefetch_pkg.sv
// Types shared across the prefetcher; widths come from the config header
`include "prefetch_cfg.svh"

package prefetch_pkg;

    // Stride learning state of the controller
    typedef enum logic [1:0] {
        PF_IDLE,
        PF_ARM,
        PF_ACTIVE,
        PF_CLEANUP
    } pf_state_e;

    // One prefetched word tagged with its address
    typedef struct packed {
        logic [`PF_ADDR_W-1:0] addr;
        logic [`PF_DATA_W-1:0] data;
    } queue_entry_t;

endpackage

//--- watchdog_timer.sv
// Timeout fires after two full prescaler periods with no activity; prescale of 0 expires every cycle
`timescale 1ns/100ps
`include "prefetch_cfg.svh"

module watchdog_timer (
    input  logic                clk,
    input  logic                resetN,
    input  logic                activity,
    input  logic [`PF_WD_W-1:0] prescale,
    output logic                timeout
);

    logic [`PF_WD_W-1:0] presc_cnt;
    logic                armed;     // First expiry seen
    logic                expiry;

    assign expiry = (presc_cnt == prescale);

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            presc_cnt <= '0;
            armed     <= 1'b0;
            timeout   <= 1'b0;
        end else begin
            timeout <= 1'b0;
            if (activity) begin
                presc_cnt <= '0;
                armed     <= 1'b0;
            end else if (expiry) begin
                presc_cnt <= '0;
                armed     <= ~armed;
                timeout   <= armed;   // Second expiry
            end else begin
                presc_cnt <= presc_cnt + 1'b1;
            end
        end
    end

endmodule

//--- prefetch_queue.sv
// In-order buffer of prefetched words; caller never pushes when full, flush wins over push
`timescale 1ns/100ps
`include "prefetch_cfg.svh"

module prefetch_queue (
    input  logic                        clk,
    input  logic                        resetN,
    input  logic                        push_valid,
    input  prefetch_pkg::queue_entry_t  push_entry,
    input  logic                        pop,
    input  logic                        flush,
    output logic                        head_valid,
    output prefetch_pkg::queue_entry_t  head_entry,
    output logic [`PF_CNT_W-1:0]        count
);

    localparam int PTR_W = $clog2(`PF_QUEUE_DEPTH);

    prefetch_pkg::queue_entry_t mem [`PF_QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_pop;

    assign head_valid = (count != '0);
    assign head_entry = mem[rd_ptr];
    assign do_pop     = pop & head_valid;

    // Storage, written on every accepted push
    always_ff @(posedge clk) begin
        if (push_valid && !flush) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_valid) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_valid, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // Both or neither
            endcase
        end
    end

endmodule

//--- read_responder.sv
// One demand read in flight; s_rresp is always OKAY
`timescale 1ns/100ps
`include "prefetch_cfg.svh"

module read_responder (
    input  logic                        clk,
    input  logic                        resetN,
    input  logic [`PF_ADDR_W-1:0]       s_araddr,
    input  logic                        s_arvalid,
    output logic                        s_arready,
    output logic [`PF_DATA_W-1:0]       s_rdata,
    output logic [1:0]                  s_rresp,
    output logic                        s_rvalid,
    input  logic                        s_rready,
    input  logic                        head_valid,
    input  prefetch_pkg::queue_entry_t  head_entry,
    input  logic                        miss_ready,
    input  logic                        miss_rvalid,
    input  logic [`PF_DATA_W-1:0]       miss_rdata,
    output logic                        acc_valid,
    output logic [`PF_ADDR_W-1:0]       acc_addr,
    output logic                        pop,
    output logic                        miss_valid,
    output logic [`PF_ADDR_W-1:0]       miss_addr
);

    typedef enum logic [1:0] {RSP_IDLE, RSP_WAIT, RSP_HOLD} rsp_state_e;

    rsp_state_e            state;
    logic                  hit;
    logic                  miss_pend;   // Miss not yet taken by the controller
    logic [`PF_ADDR_W-1:0] miss_addr_q;

    assign s_arready = (state == RSP_IDLE);
    assign s_rresp   = 2'b00;
    assign acc_valid = s_arvalid & s_arready;
    assign acc_addr  = s_araddr;
    assign hit       = head_valid && (head_entry.addr == s_araddr);
    assign pop       = acc_valid & hit;

    // A fresh miss goes out in the accept cycle so memory sees it one cycle later
    assign miss_valid = (acc_valid & ~hit) | miss_pend;
    assign miss_addr  = miss_pend ? miss_addr_q : s_araddr;

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            state     <= RSP_IDLE;
            s_rvalid  <= 1'b0;
            miss_pend <= 1'b0;
        end else begin
            case (state)
                RSP_IDLE: begin
                    if (acc_valid && hit) begin
                        s_rvalid <= 1'b1;
                        state    <= RSP_HOLD;
                    end else if (acc_valid) begin
                        miss_pend <= ~miss_ready;
                        state     <= RSP_WAIT;
                    end
                end
                RSP_WAIT: begin
                    if (miss_pend && miss_ready) begin
                        miss_pend <= 1'b0;
                    end
                    if (miss_rvalid) begin
                        s_rvalid <= 1'b1;
                        state    <= RSP_HOLD;
                    end
                end
                RSP_HOLD: begin
                    if (s_rready) begin
                        s_rvalid <= 1'b0;
                        state    <= RSP_IDLE;
                    end
                end
                default: state <= RSP_IDLE;
            endcase
        end
    end

    // Response data and miss address
    always_ff @(posedge clk) begin
        if (state == RSP_IDLE && acc_valid) begin
            s_rdata     <= head_entry.data;  // Only meaningful on a hit
            miss_addr_q <= s_araddr;
        end else if (state == RSP_WAIT && miss_rvalid) begin
            s_rdata <= miss_rdata;
        end
    end

endmodule

//--- prefetch_ctrl.sv
// Single outstanding memory read; a window above queue depth is clipped to the depth
`timescale 1ns/100ps
`include "prefetch_cfg.svh"

module prefetch_ctrl (
    input  logic                        clk,
    input  logic                        resetN,
    input  logic                        acc_valid,
    input  logic [`PF_ADDR_W-1:0]       acc_addr,
    input  logic                        miss_valid,
    input  logic [`PF_ADDR_W-1:0]       miss_addr,
    output logic                        miss_ready,
    output logic                        miss_rvalid,
    output logic [`PF_DATA_W-1:0]       miss_rdata,
    input  logic [`PF_CNT_W-1:0]        count,
    output logic                        push_valid,
    output prefetch_pkg::queue_entry_t  push_entry,
    output logic                        flush,
    output logic [`PF_ADDR_W-1:0]       m_araddr,
    output logic                        m_arvalid,
    input  logic                        m_arready,
    input  logic [`PF_DATA_W-1:0]       m_rdata,
    input  logic                        m_rvalid,
    output logic                        m_rready,
    input  logic                        ctrl_flush,
    input  logic [`PF_ADDR_W-1:0]       bar,
    input  logic [`PF_ADDR_W-1:0]       limit,
    input  logic [`PF_CNT_W-1:0]        window,
    input  logic [`PF_WD_W-1:0]         wd_prescale
);

    prefetch_pkg::pf_state_e state;

    logic [`PF_ADDR_W-1:0] prev_addr;
    logic [`PF_ADDR_W-1:0] stride;
    logic [`PF_ADDR_W-1:0] pf_addr;     // Next address to prefetch
    logic [`PF_ADDR_W-1:0] diff;
    logic [`PF_CNT_W-1:0]  inflight;
    logic                  owner_demand; // Outstanding read belongs to a miss
    logic                  busy;
    logic                  pf_issue;
    logic                  grant;
    logic                  timeout;
    logic                  wd_activity;
    logic                  ext_cleanup;

    assign diff       = acc_addr - prev_addr;
    assign busy       = m_arvalid | m_rready;
    assign miss_ready = ~busy;

    // Queued words plus the one landing this cycle
    assign inflight = count + `PF_CNT_W'(push_valid);

    // Misses win the memory channel
    assign pf_issue = (state == prefetch_pkg::PF_ACTIVE) && !busy && !miss_valid
                      && (inflight < window) && (inflight < `PF_QUEUE_DEPTH)
                      && (pf_addr >= bar) && (pf_addr <= limit);
    assign grant    = !busy && (miss_valid || pf_issue);

    assign wd_activity = acc_valid | (m_arvalid & m_arready) | (m_rvalid & m_rready);
    assign ext_cleanup = ctrl_flush | timeout;

    watchdog_timer i_watchdog_timer (
        .clk      (clk),
        .resetN   (resetN),
        .activity (wd_activity),
        .prescale (wd_prescale),
        .timeout  (timeout)
    );

    // Stride learning
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            state     <= prefetch_pkg::PF_IDLE;
            prev_addr <= '0;
            stride    <= '0;
            pf_addr   <= '0;
            flush     <= 1'b0;
        end else begin
            flush <= 1'b0;
            if (acc_valid) begin
                prev_addr <= acc_addr;
            end
            if (pf_issue) begin
                pf_addr <= pf_addr + stride;
            end
            case (state)
                prefetch_pkg::PF_IDLE: begin
                    if (acc_valid) state <= prefetch_pkg::PF_ARM;
                end
                prefetch_pkg::PF_ARM: begin
                    if (ext_cleanup) begin
                        state <= prefetch_pkg::PF_CLEANUP;
                    end else if (acc_valid && diff != '0) begin
                        state   <= prefetch_pkg::PF_ACTIVE;
                        stride  <= diff;
                        pf_addr <= acc_addr + diff;
                    end
                end
                prefetch_pkg::PF_ACTIVE: begin
                    if (ext_cleanup || (acc_valid && diff != stride)
                        || (miss_valid && count != '0)) begin
                        state <= prefetch_pkg::PF_CLEANUP;
                    end
                end
                prefetch_pkg::PF_CLEANUP: begin
                    // Last prefetch must land in the queue before the flush
                    if (!busy && !push_valid) begin
                        flush <= 1'b1;
                        state <= prefetch_pkg::PF_IDLE;
                    end
                end
                default: state <= prefetch_pkg::PF_IDLE;
            endcase
        end
    end

    // Memory channel
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            m_arvalid    <= 1'b0;
            m_rready     <= 1'b0;
            owner_demand <= 1'b0;
            miss_rvalid  <= 1'b0;
            push_valid   <= 1'b0;
        end else begin
            miss_rvalid <= 1'b0;
            push_valid  <= 1'b0;
            if (grant) begin
                m_arvalid    <= 1'b1;
                owner_demand <= miss_valid;
            end
            if (m_arvalid && m_arready) begin
                m_arvalid <= 1'b0;
                m_rready  <= 1'b1;
            end
            if (m_rvalid && m_rready) begin
                m_rready    <= 1'b0;
                miss_rvalid <= owner_demand;
                push_valid  <= ~owner_demand;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            m_araddr <= miss_valid ? miss_addr : pf_addr;
        end
        if (m_rvalid && m_rready) begin
            miss_rdata      <= m_rdata;
            push_entry.addr <= m_araddr;  // Held for the whole read
            push_entry.data <= m_rdata;
        end
    end

endmodule

//--- prefetcher_top.sv
// Read-only AXI4-Lite stride prefetcher; bar, limit, window and wd_prescale must be static
`timescale 1ns/100ps
`include "prefetch_cfg.svh"

module prefetcher_top (
    input  logic                  clk,
    input  logic                  resetN,
    input  logic [`PF_ADDR_W-1:0] s_araddr,
    input  logic                  s_arvalid,
    output logic                  s_arready,
    output logic [`PF_DATA_W-1:0] s_rdata,
    output logic [1:0]            s_rresp,
    output logic                  s_rvalid,
    input  logic                  s_rready,
    output logic [`PF_ADDR_W-1:0] m_araddr,
    output logic                  m_arvalid,
    input  logic                  m_arready,
    input  logic [`PF_DATA_W-1:0] m_rdata,
    input  logic                  m_rvalid,
    output logic                  m_rready,
    input  logic                  ctrl_flush,
    input  logic [`PF_ADDR_W-1:0] bar,
    input  logic [`PF_ADDR_W-1:0] limit,
    input  logic [`PF_CNT_W-1:0]  window,
    input  logic [`PF_WD_W-1:0]   wd_prescale
);

    // Responder to controller
    logic                  acc_valid;
    logic [`PF_ADDR_W-1:0] acc_addr;
    logic                  miss_valid;
    logic [`PF_ADDR_W-1:0] miss_addr;
    logic                  miss_ready;
    logic                  miss_rvalid;
    logic [`PF_DATA_W-1:0] miss_rdata;

    // Queue side
    logic                       push_valid;
    prefetch_pkg::queue_entry_t push_entry;
    logic                       head_valid;
    prefetch_pkg::queue_entry_t head_entry;
    logic                       pop;
    logic                       flush;
    logic [`PF_CNT_W-1:0]       count;

    read_responder i_read_responder (
        .clk(clk), .resetN(resetN),
        .s_araddr(s_araddr), .s_arvalid(s_arvalid), .s_arready(s_arready),
        .s_rdata(s_rdata), .s_rresp(s_rresp), .s_rvalid(s_rvalid), .s_rready(s_rready),
        .head_valid(head_valid), .head_entry(head_entry),
        .miss_ready(miss_ready), .miss_rvalid(miss_rvalid), .miss_rdata(miss_rdata),
        .acc_valid(acc_valid), .acc_addr(acc_addr), .pop(pop),
        .miss_valid(miss_valid), .miss_addr(miss_addr)
    );

    prefetch_queue i_prefetch_queue (
        .clk(clk), .resetN(resetN),
        .push_valid(push_valid), .push_entry(push_entry),
        .pop(pop), .flush(flush),
        .head_valid(head_valid), .head_entry(head_entry), .count(count)
    );

    prefetch_ctrl i_prefetch_ctrl (
        .clk(clk), .resetN(resetN),
        .acc_valid(acc_valid), .acc_addr(acc_addr),
        .miss_valid(miss_valid), .miss_addr(miss_addr), .miss_ready(miss_ready),
        .miss_rvalid(miss_rvalid), .miss_rdata(miss_rdata),
        .count(count), .push_valid(push_valid), .push_entry(push_entry), .flush(flush),
        .m_araddr(m_araddr), .m_arvalid(m_arvalid), .m_arready(m_arready),
        .m_rdata(m_rdata), .m_rvalid(m_rvalid), .m_rready(m_rready),
        .ctrl_flush(ctrl_flush), .bar(bar), .limit(limit),
        .window(window), .wd_prescale(wd_prescale)
    );

endmodule

//--- prefetcher_props.sv
// Bound to prefetcher_top; bar and limit are taken as static while reads are in flight
`timescale 1ns/100ps
`include "prefetch_cfg.svh"

module prefetcher_props (
    input logic                  clk,
    input logic                  resetN,
    input logic [`PF_ADDR_W-1:0] s_araddr,
    input logic                  s_arvalid,
    input logic                  s_arready,
    input logic [`PF_DATA_W-1:0] s_rdata,
    input logic                  s_rvalid,
    input logic                  s_rready,
    input logic [`PF_ADDR_W-1:0] m_araddr,
    input logic                  m_arvalid,
    input logic                  m_arready,
    input logic [`PF_ADDR_W-1:0] bar,
    input logic [`PF_ADDR_W-1:0] limit
);

    logic [`PF_ADDR_W-1:0] demand_addr;  // Last accepted demand address

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            demand_addr <= '0;
        end else if (s_arvalid && s_arready) begin
            demand_addr <= s_araddr;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (!resetN)
        m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddr))
        else $error("m_arvalid dropped or m_araddr changed before m_arready");

    r_hold: assert property (@(posedge clk) disable iff (!resetN)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata))
        else $error("s_rvalid dropped or s_rdata changed before s_rready");

    // Misses may go anywhere, prefetches stay in the window
    ar_range: assert property (@(posedge clk) disable iff (!resetN)
        m_arvalid |-> (m_araddr >= bar && m_araddr <= limit) || m_araddr == demand_addr)
        else $error("memory read address outside bar..limit and not a demand miss");

endmodule

//--- prefetcher_tb.sv
// Directed tests; the memory model answers one read at a time after a random AR stall
`timescale 1ns/100ps
`include "prefetch_cfg.svh"

module prefetcher_tb;

    localparam int WINDOW    = 4;
    localparam int PRESCALE  = 100;
    localparam int NUM_READS = 30;   // Slave reads over all tests
    localparam logic [`PF_DATA_W-1:0] DATA_KEY = 32'h5a5a_0000;
    localparam logic [1:0] RESP_OKAY = 2'b00;

    logic                  clk;
    logic                  resetN;
    logic [`PF_ADDR_W-1:0] s_araddr;
    logic                  s_arvalid;
    logic                  s_arready;
    logic [`PF_DATA_W-1:0] s_rdata;
    logic [1:0]            s_rresp;
    logic                  s_rvalid;
    logic                  s_rready;
    logic [`PF_ADDR_W-1:0] m_araddr;
    logic                  m_arvalid;
    logic                  m_arready;
    logic [`PF_DATA_W-1:0] m_rdata;
    logic                  m_rvalid;
    logic                  m_rready;
    logic                  ctrl_flush;
    logic [`PF_ADDR_W-1:0] bar;
    logic [`PF_ADDR_W-1:0] limit;
    logic [`PF_CNT_W-1:0]  window;
    logic [`PF_WD_W-1:0]   wd_prescale;

    integer                seed = 32'h9448_bd59;
    int                    errors = 0;
    int                    checks = 0;
    int                    ar_count;
    logic [`PF_ADDR_W-1:0] ar_log [$];   // Every memory AR in order

    prefetcher_top i_prefetcher_top (.*);

    bind prefetcher_top prefetcher_props i_prefetcher_props (
        .clk(clk), .resetN(resetN),
        .s_araddr(s_araddr), .s_arvalid(s_arvalid), .s_arready(s_arready),
        .s_rdata(s_rdata), .s_rvalid(s_rvalid), .s_rready(s_rready),
        .m_araddr(m_araddr), .m_arvalid(m_arvalid), .m_arready(m_arready),
        .bar(bar), .limit(limit)
    );

    always #2 clk = ~clk;   // 4 ns period

    function automatic logic [`PF_DATA_W-1:0] model_data(input logic [`PF_ADDR_W-1:0] addr);
        return addr ^ DATA_KEY;
    endfunction

    initial begin : memory_model
        int                    lat;
        int                    stall;
        logic [`PF_ADDR_W-1:0] rd_addr;
        m_arready = 1'b0;
        m_rvalid  = 1'b0;
        m_rdata   = '0;
        ar_count  = 0;
        forever begin
            @(posedge clk);
            if (m_arvalid) begin
                stall = $unsigned($random(seed)) % 32'd3;   // Extra AR wait cycles
                repeat (stall) @(posedge clk);
                #1;
                m_arready = 1'b1;
                @(posedge clk);   // AR handshake
                rd_addr  = m_araddr;
                ar_count = ar_count + 1;
                ar_log.push_back(rd_addr);
                lat = 1 + ($unsigned($random(seed)) % 32'd4);
                #1;
                m_arready = 1'b0;
                repeat (lat - 1) begin
                    @(posedge clk);
                    #1;
                end
                m_rvalid = 1'b1;
                m_rdata  = model_data(rd_addr);
                @(posedge clk);
                while (!m_rready) @(posedge clk);
                #1;
                m_rvalid = 1'b0;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks = checks + 1;
        if (expected !== actual) begin
            errors = errors + 1;
            $display("[ERROR] %s: expected 0x%h, actual 0x%h", name, expected, actual);
        end
    endtask

    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic read_word(input logic [`PF_ADDR_W-1:0] addr, input int stall,
                             output logic [`PF_DATA_W-1:0] data, output logic [1:0] resp);
        s_araddr  = addr;
        s_arvalid = 1'b1;
        @(posedge clk);
        while (!s_arready) @(posedge clk);
        #1;
        s_arvalid = 1'b0;
        if (stall > 0) begin
            tick(stall);   // Slave back-pressure
        end
        s_rready = 1'b1;
        @(posedge clk);
        while (!s_rvalid) @(posedge clk);
        data = s_rdata;
        resp = s_rresp;
        #1;
        s_rready = 1'b0;
    endtask

    task automatic read_check(input string name, input logic [`PF_ADDR_W-1:0] addr,
                              input int stall);
        logic [`PF_DATA_W-1:0] data;
        logic [1:0]            resp;
        read_word(addr, stall, data, resp);
        check_value(name, model_data(addr), data);
        check_value({name, "_rresp"}, 32'(RESP_OKAY), 32'(resp));
    endtask

    // The read must go to memory as its own AR
    task automatic expect_demand_miss(input string name, input logic [`PF_ADDR_W-1:0] addr,
                                      input int stall);
        int mark;
        mark = ar_count;
        read_check(name, addr, stall);
        check_value({name, "_ar_count"}, mark + 1, ar_count);
        check_value({name, "_ar_addr"}, addr, ar_log[$]);
    endtask

    task automatic wait_ar_count(input int n);
        while (ar_count < n) tick(1);
        tick(8);   // Last word lands in the queue
    endtask

    task automatic flush_and_settle();
        ctrl_flush = 1'b1;
        tick(1);
        ctrl_flush = 1'b0;
        tick(20);
    endtask

    task automatic learn_stream(input string name, input logic [`PF_ADDR_W-1:0] base,
                                input logic [`PF_ADDR_W-1:0] stride, input int prefetches);
        int mark;
        mark = ar_count;
        read_check(name, base, 0);
        read_check(name, base + stride, 0);
        wait_ar_count(mark + 2 + prefetches);
    endtask

    task automatic test_isolated();
        logic [`PF_ADDR_W-1:0] addrs [3];
        addrs = '{32'h0000_0100, 32'h0004_2a38, 32'h00f0_0014};
        for (int i = 0; i < 3; i++) begin
            flush_and_settle();   // Back to idle, nothing learned
            expect_demand_miss("isolated", addrs[i], i);
        end
    endtask

    task automatic test_stride();
        logic [`PF_ADDR_W-1:0] base;
        logic [`PF_ADDR_W-1:0] stride;
        int                    mark;
        base   = 32'h0000_1000;
        stride = 32'h10;
        flush_and_settle();
        mark = ar_count;
        learn_stream("stride_learn", base, stride, WINDOW);
        for (int k = 2; k < 6; k++) begin
            read_check("stride_hit", base + 32'(k) * stride, k % 2);
        end
        wait_ar_count(mark + 2 + WINDOW + 4);   // One refill per hit
        check_value("stride_ar_count", mark + 2 + WINDOW + 4, ar_count);
        for (int k = 0; k < 2 + WINDOW + 4; k++) begin
            check_value("stride_ar_addr", base + 32'(k) * stride, ar_log[mark + k]);
        end
    endtask

    task automatic test_window();
        int mark;
        flush_and_settle();
        mark = ar_count;
        learn_stream("window_learn", 32'h0000_2000, 32'h20, WINDOW);
        tick(40);
        check_value("window_prefetches", WINDOW, ar_count - mark - 2);
    endtask

    task automatic test_limit();
        logic [`PF_ADDR_W-1:0] base;
        logic [`PF_ADDR_W-1:0] stride;
        int                    mark;
        base   = 32'h0000_3000;
        stride = 32'd4;
        flush_and_settle();
        limit = base + 32'd3 * stride;   // Room for two prefetches
        mark  = ar_count;
        learn_stream("limit_learn", base, stride, 2);
        for (int k = 2; k < 6; k++) begin
            read_check("limit_read", base + 32'(k) * stride, 0);
        end
        check_value("limit_ar_count", mark + 6, ar_count);
        for (int k = 0; k < 6; k++) begin
            check_value("limit_ar_addr", base + 32'(k) * stride, ar_log[mark + k]);
        end
        limit = '1;
    endtask

    task automatic test_stride_change();
        logic [`PF_ADDR_W-1:0] base;
        int                    mark;
        base = 32'h0000_5000;
        flush_and_settle();
        learn_stream("change_learn", base, 32'd8, WINDOW);
        read_check("change_hit", base + 32'd16, 0);
        read_check("change_jump", base + 32'h100, 2);   // Breaks the stride
        tick(20);
        // Was queued before the jump, so only a flushed queue sends it to memory
        expect_demand_miss("change_after", base + 32'h18, 0);
        mark = ar_count;
        read_check("change_relearn", base + 32'h20, 1);
        wait_ar_count(mark + 1 + WINDOW);
        read_check("change_relearn_hit", base + 32'h28, 0);
        check_value("change_relearn_ar", base + 32'h28, ar_log[mark + 1]);
    endtask

    task automatic test_flush();
        flush_and_settle();
        learn_stream("flush_learn", 32'h0000_6000, 32'd4, WINDOW);
        flush_and_settle();   // Drops the queued words
        expect_demand_miss("flush_after", 32'h0000_6008, 1);
    endtask

    task automatic test_idle_timeout();
        flush_and_settle();
        learn_stream("idle_learn", 32'h0000_7000, 32'd4, WINDOW);
        tick(3 * (PRESCALE + 1) + 20);   // Two watchdog expiries and cleanup
        expect_demand_miss("idle_after", 32'h0000_7008, 0);
    endtask

    initial begin : run_limit
        repeat (NUM_READS * 200 + 1000) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", NUM_READS * 200 + 1000);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        resetN      = 1'b0;
        s_araddr    = '0;
        s_arvalid   = 1'b0;
        s_rready    = 1'b0;
        ctrl_flush  = 1'b0;
        bar         = '0;
        limit       = '1;
        window      = `PF_CNT_W'(WINDOW);
        wd_prescale = `PF_WD_W'(PRESCALE);
        repeat (10) @(posedge clk);
        #1;
        resetN = 1'b1;
        tick(2);
        test_isolated();
        test_stride();
        test_window();
        test_limit();
        test_stride_change();
        test_flush();
        test_idle_timeout();
        $display("Done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+.
prefetch_pkg.sv
watchdog_timer.sv
prefetch_queue.sv
read_responder.sv
prefetch_ctrl.sv
prefetcher_top.sv
prefetcher_props.sv
prefetcher_tb.sv

//--- Makefile
SRCS = prefetch_cfg.svh prefetch_pkg.sv watchdog_timer.sv prefetch_queue.sv \
       read_responder.sv prefetch_ctrl.sv prefetcher_top.sv prefetcher_props.sv \
       prefetcher_tb.sv

.PHONY: run clean

run: obj_dir/Vprefetcher_tb
	./obj_dir/Vprefetcher_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "SIMULATION FAILED" sim.log
	grep -q "SIMULATION PASSED" sim.log

obj_dir/Vprefetcher_tb: $(SRCS) list.f
	verilator --binary --timing --assert --top-module prefetcher_tb -Mdir obj_dir -f list.f

clean:
	rm -rf obj_dir sim.log
